// ==== la_decode.f ====
+incdir+verification
verilog/la_decode_pkg.sv
verilog/inst_fifo.sv
verilog/opcode_major_decode.sv
verilog/opcode_reg_decode.sv
verilog/decode_merge.sv
verilog/la_decode_top.sv
verification/tb_la_decode_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the la_decode testbench with Verilator
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f la_decode.f --top-module tb_la_decode_top -o tb_la_decode_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_la_decode_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    exit 0
fi
exit 1

// ==== verification/tb_decode_ref.svh ====
//********************
// reference decode built from the ISA encodings
// table order is register family first, then the major family
// everything outside the table is illegal with no alu op
//********************
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

localparam int N_KEPT = 48;
localparam int N_REG  = 23;   // entries below this index are register family

localparam logic [31:0] KEPT_MATCH [N_KEPT] = '{
    32'h00100000, 32'h00110000, 32'h00120000, 32'h00128000, 32'h00140000, 32'h00148000,
    32'h00150000, 32'h00158000, 32'h00160000, 32'h00168000, 32'h00170000, 32'h00178000,
    32'h00180000, 32'h001c0000, 32'h001c8000, 32'h001d0000, 32'h00200000, 32'h00208000,
    32'h00210000, 32'h00218000, 32'h00408000, 32'h00448000, 32'h00488000,
    32'h02000000, 32'h02400000, 32'h02800000, 32'h03400000, 32'h03800000, 32'h03c00000,
    32'h28000000, 32'h28400000, 32'h28800000, 32'h2a000000, 32'h2a400000,
    32'h29000000, 32'h29400000, 32'h29800000,
    32'h4c000000, 32'h50000000, 32'h54000000, 32'h58000000, 32'h5c000000, 32'h60000000,
    32'h64000000, 32'h68000000, 32'h6c000000,
    32'h14000000, 32'h1c000000
};

localparam inst_op_e KEPT_OP [N_KEPT] = '{
    OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_NOR, OP_AND, OP_OR, OP_XOR, OP_ORN, OP_ANDN,
    OP_SLL_W, OP_SRL_W, OP_SRA_W, OP_MUL_W, OP_MULH_W, OP_MULH_WU,
    OP_DIV_W, OP_MOD_W, OP_DIV_WU, OP_MOD_WU, OP_SLLI_W, OP_SRLI_W, OP_SRAI_W,
    OP_SLTI, OP_SLTUI, OP_ADDI_W, OP_ANDI, OP_ORI, OP_XORI,
    OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU, OP_ST_B, OP_ST_H, OP_ST_W,
    OP_JIRL, OP_B, OP_BL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LU12I_W, OP_PCADDU12I
};

// expected alu op per table entry
localparam alu_op_e KEPT_ALU [N_KEPT] = '{
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND, ALU_OR, ALU_XOR, ALU_ORN, ALU_ANDN,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHU,
    ALU_DIV, ALU_MOD, ALU_DIVU, ALU_MODU, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_ADD, ALU_AND, ALU_OR, ALU_XOR,
    ALU_ADD, ALU_ADD, ALU_ADD, ALU_ADD, ALU_ADD, ALU_ADD, ALU_ADD, ALU_ADD,
    ALU_NONE, ALU_NONE, ALU_NONE, ALU_NONE, ALU_NONE, ALU_NONE, ALU_NONE, ALU_NONE, ALU_NONE,
    ALU_NONE, ALU_ADD
};

function automatic logic [31:0] kept_mask(input int i);
    if (i < N_REG) begin
        return 32'hffff8000;   // opcode in bits 31..15
    end else if (i < 37) begin
        return 32'hffc00000;   // 2RI12 and memory
    end else if (i < 46) begin
        return 32'hfc000000;
    end
    return 32'hfe000000;       // upper imm, bit 25 clear
endfunction

function automatic void ref_decode(input logic [31:0] w, output inst_op_e op,
                                   output alu_op_e alu, output logic illegal);
    op      = OP_ILLEGAL;
    alu     = ALU_NONE;
    illegal = 1'b1;
    for (int i = 0; i < N_KEPT; i++) begin
        if ((w & kept_mask(i)) == KEPT_MATCH[i]) begin
            op      = KEPT_OP[i];
            alu     = KEPT_ALU[i];
            illegal = 1'b0;
        end
    end
endfunction

`endif

// ==== verification/tb_la_decode_top.sv ====
//********************
// testbench for la_decode_top, FIFO_DEPTH 4 and OUT_CREDITS 2
// sender and sink follow the credit rules, outputs checked in order
// run ends at a cycle limit derived from the number of words
//********************
`timescale 1ns/1ps

module tb_la_decode_top;
    import la_decode_pkg::*;

    `include "tb_decode_ref.svh"

    localparam int FIFO_DEPTH  = 4;
    localparam int OUT_CREDITS = 2;
    localparam int N_ITEMS     = 2 * N_KEPT + 7 + 20 + 12 + 200 + 300;
    localparam int MAX_CYCLES  = 20 * N_ITEMS + 200;

    localparam logic [31:0] DROPPED [7] = '{
        32'h002b0000, 32'h002a0000, 32'h04000000, 32'h06482800,   // syscall break csrrd tlbsrch
        32'h38720000, 32'h20000000, 32'h18000000                  // dbar ll.w pcaddi
    };

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        in_valid = 1'b0;
    logic [31:0] in_inst = '0;
    logic        out_credit = 1'b0;
    logic        in_credit;
    logic        out_valid;
    inst_op_e    out_op;
    alu_op_e     out_alu_op;
    logic        out_illegal;
    logic [31:0] out_inst;

    logic [31:0] send_q[$];      // words waiting for an input credit
    logic [31:0] exp_inst_q[$];
    int          exp_cyc_q[$];   // send cycle of each outstanding word
    int          ret_q[$];       // cycle at which each sink credit is due
    int          cycle = 0;
    int          credits = FIFO_DEPTH;
    int          errors = 0;
    int          tests = 0;
    int          sent = 0;
    int          outs = 0;
    int          in_credits = 0;
    int          sink_delay = 0;
    logic        sink_hold = 1'b0;
    integer      seed = 32'h500ebcae;

    la_decode_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut (
        .clk_i         (clk),
        .rst_i         (rst),
        .in_valid_i    (in_valid),
        .in_inst_i     (in_inst),
        .out_credit_i  (out_credit),
        .in_credit_o   (in_credit),
        .out_valid_o   (out_valid),
        .out_op_o      (out_op),
        .out_alu_op_o  (out_alu_op),
        .out_illegal_o (out_illegal),
        .out_inst_o    (out_inst)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d words never came out", cycle, exp_inst_q.size());
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic report(input string name, input int errors_before);
        tests = tests + 1;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
    endtask

    task automatic wait_drained();
        while (send_q.size() != 0 || exp_inst_q.size() != 0 || ret_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // two copies of each entry, random bits outside the opcode fields
    task automatic queue_kept(input int lo, input int hi);
        for (int r = 0; r < 2; r++) begin
            for (int i = lo; i < hi; i++) begin
                send_q.push_back(KEPT_MATCH[i] | ($random(seed) & ~kept_mask(i)));
            end
        end
    endtask

    // sender, spends one credit per word
    always @(negedge clk) begin
        logic [31:0] w;
        if (in_credit) begin
            credits    = credits + 1;
            in_credits = in_credits + 1;
        end
        if (send_q.size() > 0 && credits > 0) begin
            w = send_q.pop_front();
            credits = credits - 1;
            in_valid <= 1'b1;
            in_inst  <= w;
            exp_inst_q.push_back(w);
            exp_cyc_q.push_back(cycle);
            sent = sent + 1;
        end else begin
            in_valid <= 1'b0;
        end
    end

    // sink, returns one credit per cycle once due
    always @(negedge clk) begin
        if (out_valid) begin
            ret_q.push_back(cycle + sink_delay);
        end
        if (!sink_hold && ret_q.size() > 0 && ret_q[0] <= cycle) begin
            void'(ret_q.pop_front());
            out_credit <= 1'b1;
        end else begin
            out_credit <= 1'b0;
        end
    end

    always @(negedge clk) begin
        logic [31:0] w;
        int          sent_at;
        inst_op_e    e_op;
        alu_op_e     e_alu;
        logic        e_ill;
        if (out_valid) begin
            outs = outs + 1;
            if (exp_inst_q.size() == 0) begin
                $display("unexpected output 0x%08h at %0t, no word was outstanding", out_inst, $time);
                errors = errors + 1;
            end else begin
                w       = exp_inst_q.pop_front();
                sent_at = exp_cyc_q.pop_front();
                ref_decode(w, e_op, e_alu, e_ill);
                check_value(out_inst, w, "instruction word");
                check_value(32'(out_op), 32'(e_op), "op");
                check_value(32'(out_alu_op), 32'(e_alu), "alu op");
                check_value(32'(out_illegal), 32'(e_ill), "illegal flag");
                if (cycle - sent_at < 2) begin
                    $display("word 0x%08h came out %0d cycles after it was sent, at least 2 expected",
                             w, cycle - sent_at);
                    errors = errors + 1;
                end
            end
        end
    end

    initial begin
        int          e0;
        int          sent0;
        int          cred0;
        int          outs0;
        int          c0;
        int          n;
        logic [31:0] w;
        inst_op_e    e_op;
        alu_op_e     e_alu;
        logic        e_ill;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);

        e0 = errors;
        queue_kept(0, N_REG);
        wait_drained();
        report("register families", e0);

        e0 = errors;
        queue_kept(N_REG, N_KEPT);
        wait_drained();
        report("major families", e0);

        e0 = errors;
        for (int i = 0; i < 7; i++) begin
            send_q.push_back(DROPPED[i] | ($random(seed) & 32'h00007fff));
        end
        n = 0;
        while (n < 20) begin
            w = $random(seed);
            ref_decode(w, e_op, e_alu, e_ill);
            if (e_ill) begin
                send_q.push_back(w);
                n = n + 1;
            end
        end
        wait_drained();
        report("illegal encodings", e0);

        e0 = errors;
        sink_hold = 1'b1;   // sink keeps every slot
        sent0 = sent;
        cred0 = in_credits;
        outs0 = outs;
        repeat (12) send_q.push_back($random(seed));
        repeat (40) @(posedge clk);
        check_value(outs - outs0, OUT_CREDITS, "outputs while sink holds");
        check_value(in_credits - cred0, OUT_CREDITS, "input credits while sink holds");
        check_value(sent - sent0, FIFO_DEPTH + OUT_CREDITS, "words accepted while sink holds");
        sink_hold = 1'b0;
        wait_drained();
        report("back-pressure", e0);

        e0 = errors;
        sink_delay = 3;
        sent0 = sent;
        cred0 = in_credits;
        outs0 = outs;
        repeat (200) send_q.push_back($random(seed));
        wait_drained();
        check_value(outs - outs0, 200, "outputs in burst");
        check_value(in_credits - cred0, sent - sent0, "input credits in burst");
        report("credit accounting", e0);

        e0 = errors;
        sink_delay = 0;
        c0 = cycle;
        repeat (300) begin
            n = $unsigned($random(seed)) % (N_KEPT + 16);
            w = $random(seed);
            if (n < N_KEPT) begin
                w = KEPT_MATCH[n] | (w & ~kept_mask(n));
            end
            send_q.push_back(w);
        end
        wait_drained();
        if (cycle - c0 > 310) begin
            $display("stream of 300 words took %0d cycles, not full rate", cycle - c0);
            errors = errors + 1;
        end
        report("full-rate stream", e0);

        $display("%0d tests, %0d words sent, %0d outputs, %0d errors", tests, sent, outs, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verilog/decode_merge.sv ====
//********************
// merges both decoder results and maps op to alu op
// output credits start at OUT_CREDITS, sink returns one per item
// one result per cycle at most
//********************
`timescale 1ns/1ps

module decode_merge #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             head_valid_i,
    input  logic [la_decode_pkg::INST_W-1:0] head_inst_i,
    input  logic                             major_hit_i,
    input  la_decode_pkg::inst_op_e          major_op_i,
    input  logic                             reg_hit_i,
    input  la_decode_pkg::inst_op_e          reg_op_i,
    input  logic                             out_credit_i,
    output logic                             pop_o,
    output logic                             out_valid_o,
    output la_decode_pkg::inst_op_e          out_op_o,
    output la_decode_pkg::alu_op_e           out_alu_op_o,
    output logic                             out_illegal_o,
    output logic [la_decode_pkg::INST_W-1:0] out_inst_o
);
    import la_decode_pkg::*;

    logic [CREDIT_W-1:0] credit_q;
    inst_op_e            sel_op;
    alu_op_e             sel_alu_op;
    logic                sel_illegal;

    function automatic alu_op_e to_alu_op(input inst_op_e op);
        case (op)
            OP_ADD_W, OP_ADDI_W, OP_PCADDU12I:   return ALU_ADD;
            OP_LD_B, OP_LD_H, OP_LD_W:           return ALU_ADD;
            OP_LD_BU, OP_LD_HU:                  return ALU_ADD;
            OP_ST_B, OP_ST_H, OP_ST_W:           return ALU_ADD;
            OP_SUB_W:                            return ALU_SUB;
            OP_SLT, OP_SLTI:                     return ALU_SLT;
            OP_SLTU, OP_SLTUI:                   return ALU_SLTU;
            OP_NOR:                              return ALU_NOR;
            OP_AND, OP_ANDI:                     return ALU_AND;
            OP_OR, OP_ORI:                       return ALU_OR;
            OP_XOR, OP_XORI:                     return ALU_XOR;
            OP_ORN:                              return ALU_ORN;
            OP_ANDN:                             return ALU_ANDN;
            OP_SLL_W, OP_SLLI_W:                 return ALU_SLL;
            OP_SRL_W, OP_SRLI_W:                 return ALU_SRL;
            OP_SRA_W, OP_SRAI_W:                 return ALU_SRA;
            OP_MUL_W:                            return ALU_MUL;
            OP_MULH_W:                           return ALU_MULH;
            OP_MULH_WU:                          return ALU_MULHU;
            OP_DIV_W:                            return ALU_DIV;
            OP_MOD_W:                            return ALU_MOD;
            OP_DIV_WU:                           return ALU_DIVU;
            OP_MOD_WU:                           return ALU_MODU;
            default:                             return ALU_NONE;  // branches, lu12i, illegal
        endcase
    endfunction

    assign sel_illegal = ~(major_hit_i | reg_hit_i);
    assign sel_op      = major_hit_i ? major_op_i :
                         reg_hit_i   ? reg_op_i   : OP_ILLEGAL;
    assign sel_alu_op  = to_alu_op(sel_op);

    // pop only with a free slot downstream
    assign pop_o = head_valid_i & (credit_q != '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_q    <= CREDIT_W'(OUT_CREDITS);
            out_valid_o <= 1'b0;
        end else begin
            credit_q    <= credit_q + CREDIT_W'(out_credit_i) - CREDIT_W'(pop_o);
            out_valid_o <= pop_o;
        end
    end

    // result payload
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            out_op_o      <= sel_op;
            out_alu_op_o  <= sel_alu_op;
            out_illegal_o <= sel_illegal;
            out_inst_o    <= head_inst_i;
        end
    end

endmodule

// ==== verilog/inst_fifo.sv ====
//********************
// instruction buffer, FIFO_DEPTH entries
// push while full is not checked, the sender's credits prevent it
// credit_o pulses with every entry that leaves
//********************
`timescale 1ns/1ps

module inst_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             push_i,
    input  logic [la_decode_pkg::INST_W-1:0] push_inst_i,
    input  logic                             pop_i,
    output logic                             head_valid_o,
    output logic [la_decode_pkg::INST_W-1:0] head_inst_o,
    output logic                             credit_o
);
    import la_decode_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [INST_W-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              do_pop;

    // wraps at FIFO_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign head_valid_o = (count_q != '0);
    assign head_inst_o  = mem_q[rd_ptr_q];
    assign do_pop       = pop_i & head_valid_o;   // ignore pop on empty
    assign credit_o     = do_pop;                 // one credit per leaving entry

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(do_pop);
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_inst_i;
        end
    end

endmodule

// ==== verilog/la_decode_pkg.sv ====
//********************
// shared types for the decode stage
// opcode values are internal codes, not instruction encodings
// credit counters wrap above 15, keep FIFO_DEPTH and OUT_CREDITS at 15 or less
//********************

package la_decode_pkg;

    localparam int INST_W   = 32;
    localparam int CREDIT_W = 4;

    // opcode field positions in the instruction word
    localparam int OP6_MSB = 31;
    localparam int OP6_LSB = 26;
    localparam int OP4_MSB = 25;   // also the bit that qualifies lu12i.w / pcaddu12i
    localparam int OP4_LSB = 22;
    localparam int OP2_MSB = 21;
    localparam int OP2_LSB = 20;
    localparam int OP5_MSB = 19;
    localparam int OP5_LSB = 15;

    typedef enum logic [5:0] {
        OP_ILLEGAL,
        // 3R integer
        OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU,
        OP_NOR, OP_AND, OP_OR, OP_XOR, OP_ORN, OP_ANDN,
        OP_SLL_W, OP_SRL_W, OP_SRA_W,
        // multiply / divide
        OP_MUL_W, OP_MULH_W, OP_MULH_WU,
        OP_DIV_W, OP_MOD_W, OP_DIV_WU, OP_MOD_WU,
        // shift by immediate
        OP_SLLI_W, OP_SRLI_W, OP_SRAI_W,
        // 2RI12
        OP_SLTI, OP_SLTUI, OP_ADDI_W, OP_ANDI, OP_ORI, OP_XORI,
        // memory
        OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU,
        OP_ST_B, OP_ST_H, OP_ST_W,
        // control flow
        OP_JIRL, OP_B, OP_BL,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        // upper immediate
        OP_LU12I_W, OP_PCADDU12I
    } inst_op_e;

    typedef enum logic [4:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_NOR,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_ORN,
        ALU_ANDN,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHU,
        ALU_DIV,
        ALU_MOD,
        ALU_DIVU,
        ALU_MODU
    } alu_op_e;

endpackage

// ==== verilog/la_decode_top.sv ====
//********************
// decode stage, credit flow on both sides
// sender starts with FIFO_DEPTH credits, sink owns OUT_CREDITS slots
// best case latency 2 cycles from accept to out_valid_o
//********************
`timescale 1ns/1ps

module la_decode_top #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             in_valid_i,
    input  logic [la_decode_pkg::INST_W-1:0] in_inst_i,
    input  logic                             out_credit_i,
    output logic                             in_credit_o,
    output logic                             out_valid_o,
    output la_decode_pkg::inst_op_e          out_op_o,
    output la_decode_pkg::alu_op_e           out_alu_op_o,
    output logic                             out_illegal_o,
    output logic [la_decode_pkg::INST_W-1:0] out_inst_o
);
    import la_decode_pkg::*;

    logic              head_valid;
    logic [INST_W-1:0] head_inst;
    logic              pop;
    logic              major_hit;
    inst_op_e          major_op;
    logic              reg_hit;
    inst_op_e          reg_op;

    inst_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_inst_fifo (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .push_i       (in_valid_i),
        .push_inst_i  (in_inst_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_inst_o  (head_inst),
        .credit_o     (in_credit_o)
    );

    opcode_major_decode u_major_dec (
        .inst_i (head_inst),
        .hit_o  (major_hit),
        .op_o   (major_op)
    );

    opcode_reg_decode u_reg_dec (
        .inst_i (head_inst),
        .hit_o  (reg_hit),
        .op_o   (reg_op)
    );

    decode_merge #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_merge (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .head_valid_i  (head_valid),
        .head_inst_i   (head_inst),
        .major_hit_i   (major_hit),
        .major_op_i    (major_op),
        .reg_hit_i     (reg_hit),
        .reg_op_i      (reg_op),
        .out_credit_i  (out_credit_i),
        .pop_o         (pop),
        .out_valid_o   (out_valid_o),
        .out_op_o      (out_op_o),
        .out_alu_op_o  (out_alu_op_o),
        .out_illegal_o (out_illegal_o),
        .out_inst_o    (out_inst_o)
    );

endmodule

// ==== verilog/opcode_major_decode.sv ====
//********************
// decodes families keyed by bits 31..26 and 25..22
// 2RI12 alu, loads, stores, branches, jumps, upper imm
// purely combinational
//********************
`timescale 1ns/1ps

module opcode_major_decode (
    input  logic [la_decode_pkg::INST_W-1:0] inst_i,
    output logic                             hit_o,
    output la_decode_pkg::inst_op_e          op_o
);
    import la_decode_pkg::*;

    logic [OP6_MSB-OP6_LSB:0] op6;
    logic [OP4_MSB-OP4_LSB:0] op4;
    logic                     op_b25;

    assign op6    = inst_i[OP6_MSB:OP6_LSB];
    assign op4    = inst_i[OP4_MSB:OP4_LSB];
    assign op_b25 = inst_i[OP4_MSB];

    always_comb begin
        op_o = OP_ILLEGAL;
        case (op6)
            6'h00: begin
                // op4 0 and 1 belong to the register decoder
                case (op4)
                    4'h8: op_o = OP_SLTI;
                    4'h9: op_o = OP_SLTUI;
                    4'ha: op_o = OP_ADDI_W;
                    4'hd: op_o = OP_ANDI;
                    4'he: op_o = OP_ORI;
                    4'hf: op_o = OP_XORI;
                    default: op_o = OP_ILLEGAL;
                endcase
            end
            6'h0a: begin
                case (op4)
                    4'h0: op_o = OP_LD_B;
                    4'h1: op_o = OP_LD_H;
                    4'h2: op_o = OP_LD_W;
                    4'h4: op_o = OP_ST_B;
                    4'h5: op_o = OP_ST_H;
                    4'h6: op_o = OP_ST_W;
                    4'h8: op_o = OP_LD_BU;
                    4'h9: op_o = OP_LD_HU;
                    default: op_o = OP_ILLEGAL;   // preld and friends
                endcase
            end
            6'h05: op_o = op_b25 ? OP_ILLEGAL : OP_LU12I_W;
            6'h07: op_o = op_b25 ? OP_ILLEGAL : OP_PCADDU12I;
            6'h13: op_o = OP_JIRL;
            6'h14: op_o = OP_B;
            6'h15: op_o = OP_BL;
            6'h16: op_o = OP_BEQ;
            6'h17: op_o = OP_BNE;
            6'h18: op_o = OP_BLT;
            6'h19: op_o = OP_BGE;
            6'h1a: op_o = OP_BLTU;
            6'h1b: op_o = OP_BGEU;
            default: op_o = OP_ILLEGAL;
        endcase
    end

    assign hit_o = (op_o != OP_ILLEGAL);

endmodule

// ==== verilog/opcode_reg_decode.sv ====
//********************
// decodes the op6 == 0 register formats
// 3R alu, mul/div, shift by immediate
// never hits together with opcode_major_decode
//********************
`timescale 1ns/1ps

module opcode_reg_decode (
    input  logic [la_decode_pkg::INST_W-1:0] inst_i,
    output logic                             hit_o,
    output la_decode_pkg::inst_op_e          op_o
);
    import la_decode_pkg::*;

    logic [OP6_MSB-OP6_LSB:0] op6;
    logic [OP4_MSB-OP4_LSB:0] op4;
    logic [OP2_MSB-OP2_LSB:0] op2;
    logic [OP5_MSB-OP5_LSB:0] op5;

    assign op6 = inst_i[OP6_MSB:OP6_LSB];
    assign op4 = inst_i[OP4_MSB:OP4_LSB];
    assign op2 = inst_i[OP2_MSB:OP2_LSB];
    assign op5 = inst_i[OP5_MSB:OP5_LSB];

    always_comb begin
        op_o = OP_ILLEGAL;
        if (op6 == 6'h00 && op4 == 4'h0 && op2 == 2'h1) begin
            case (op5)
                5'h00: op_o = OP_ADD_W;
                5'h02: op_o = OP_SUB_W;
                5'h04: op_o = OP_SLT;
                5'h05: op_o = OP_SLTU;
                5'h08: op_o = OP_NOR;
                5'h09: op_o = OP_AND;
                5'h0a: op_o = OP_OR;
                5'h0b: op_o = OP_XOR;
                5'h0c: op_o = OP_ORN;
                5'h0d: op_o = OP_ANDN;
                5'h0e: op_o = OP_SLL_W;
                5'h0f: op_o = OP_SRL_W;
                5'h10: op_o = OP_SRA_W;
                5'h18: op_o = OP_MUL_W;
                5'h19: op_o = OP_MULH_W;
                5'h1a: op_o = OP_MULH_WU;
                default: op_o = OP_ILLEGAL;
            endcase
        end else if (op6 == 6'h00 && op4 == 4'h0 && op2 == 2'h2) begin
            // break / syscall live here too, left illegal
            case (op5)
                5'h00: op_o = OP_DIV_W;
                5'h01: op_o = OP_MOD_W;
                5'h02: op_o = OP_DIV_WU;
                5'h03: op_o = OP_MOD_WU;
                default: op_o = OP_ILLEGAL;
            endcase
        end else if (op6 == 6'h00 && op4 == 4'h1 && op2 == 2'h0) begin
            case (op5)
                5'h01: op_o = OP_SLLI_W;
                5'h09: op_o = OP_SRLI_W;
                5'h11: op_o = OP_SRAI_W;
                default: op_o = OP_ILLEGAL;
            endcase
        end
        // rdcnt* sits at op2 == 0, op4 == 0 and stays illegal
    end

    assign hit_o = (op_o != OP_ILLEGAL);

endmodule
